//--- design/apf_io_pkg.sv
// --------------------
// shared definitions for the host bridge handoff block
// address map, widths, reset values and restart hold time
// referenced by scoped name from every rtl file
// --------------------

package apf_io_pkg;

	// host bridge word types
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// top address byte of the option registers and the mask read-back
	localparam logic [7:0] CFG_SPACE  = 8'hF0;
	localparam logic [7:0] MASK_SPACE = 8'hF1;

	// rom region prefixes, compared against the top bits of the address
	localparam logic [8:0]  P2_REGION = 9'h020;
	localparam logic [12:0] M_REGION  = 13'h021F;
	localparam logic [11:0] S_REGION  = 12'h10C;
	localparam logic [7:0]  V1_REGION = 8'h20;

	// mask widths per region
	localparam int P2_MASK_W = 23;
	localparam int M_MASK_W  = 19;
	localparam int S_MASK_W  = 19;
	localparam int V1_MASK_W = 24;

	// option register offsets in the 0xF0 space
	localparam logic [15:0] OFS_CORE_RESET  = 16'h0100;
	localparam logic [15:0] OFS_DIPSW       = 16'h0104;
	localparam logic [15:0] OFS_SYSTEM_TYPE = 16'h0108;
	localparam logic [15:0] OFS_MEMCARD     = 16'h010C;
	localparam logic [15:0] OFS_OVERCLOCK   = 16'h0110;
	localparam logic [15:0] OFS_VIDEO_MODE  = 16'h0200;
	localparam logic [15:0] OFS_SCREEN_X    = 16'h0204;
	localparam logic [15:0] OFS_SCREEN_Y    = 16'h0208;
	localparam logic [15:0] OFS_VIDEO_RATIO = 16'h020C;
	localparam logic [15:0] OFS_CH_ENABLE   = 16'h0300;
	localparam logic [15:0] OFS_SND_ENABLE  = 16'h0304;
	localparam logic [15:0] OFS_PCHIP_MAIN  = 16'h0404;
	localparam logic [15:0] OFS_PCHIP_SUB   = 16'h0408;

	// mask read-back offsets in the 0xF1 space
	localparam logic [15:0] MOFS_P2 = 16'h0000;
	localparam logic [15:0] MOFS_M  = 16'h0004;
	localparam logic [15:0] MOFS_S  = 16'h0008;
	localparam logic [15:0] MOFS_V1 = 16'h000C;

	// option reset values
	localparam logic [7:0] DIPSW_RST       = 8'hFF;
	localparam logic       SYSTEM_TYPE_RST = 1'b1;
	localparam logic [5:0] CH_ENABLE_RST   = 6'h3F;
	localparam logic [3:0] SND_ENABLE_RST  = 4'hF;

	// cycles the core is held after a restart trigger
	localparam int RESTART_HOLD = 1024;

endpackage

//--- design/apf_cfg_regs.sv
// --------------------
// option registers written from the 0xF0 host bridge space
// also encodes the chip mode and raises the restart request
// read word is picked by offset, the space is checked upstream
// --------------------

`timescale 1ns/10ps

module apf_cfg_regs (
	input  logic                clk_74a,
	input  logic                reset_l_main,
	input  logic                bridge_wr,
	input  apf_io_pkg::addr_t   bridge_addr,
	input  apf_io_pkg::data_t   bridge_wr_data,
	output logic [7:0]          dipsw,
	output logic                system_type,
	output logic [1:0]          memory_card_enable,
	output logic                cpu_overclock,
	output logic                video_mode,
	output logic [2:0]          video_ratio,
	output apf_io_pkg::data_t   screen_x_pos,
	output apf_io_pkg::data_t   screen_y_pos,
	output logic [5:0]          ch_enable,
	output logic [3:0]          snd_enable,
	output logic [3:0]          cart_pchip,
	output logic                restart_req,
	output apf_io_pkg::data_t   cfg_rd_data
);

	logic        wr_cfg;
	logic [15:0] ofs;
	logic        pchip_main;
	logic [2:0]  pchip_sub;
	logic        restart_hit;

	assign wr_cfg = bridge_wr && (bridge_addr[31:24] == apf_io_pkg::CFG_SPACE);
	assign ofs    = bridge_addr[15:0];

	// core reset needs bit 0, system type and overclock restart on any write
	assign restart_hit = wr_cfg &&
		(((ofs == apf_io_pkg::OFS_CORE_RESET) && bridge_wr_data[0]) ||
		(ofs == apf_io_pkg::OFS_SYSTEM_TYPE) ||
		(ofs == apf_io_pkg::OFS_OVERCLOCK));

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			dipsw              <= apf_io_pkg::DIPSW_RST;
			system_type        <= apf_io_pkg::SYSTEM_TYPE_RST;
			memory_card_enable <= 2'b00;
			cpu_overclock      <= 1'b0;
			video_mode         <= 1'b0;
			video_ratio        <= 3'd0;
			screen_x_pos       <= '0;
			screen_y_pos       <= '0;
			ch_enable          <= apf_io_pkg::CH_ENABLE_RST;
			snd_enable         <= apf_io_pkg::SND_ENABLE_RST;
			pchip_main         <= 1'b0;
			pchip_sub          <= 3'd0;
			restart_req        <= 1'b0;
		end else begin
			restart_req <= restart_hit;
			if (wr_cfg) begin
				case (ofs)
					apf_io_pkg::OFS_DIPSW:       dipsw <= bridge_wr_data[7:0];
					apf_io_pkg::OFS_SYSTEM_TYPE: system_type <= bridge_wr_data[0];
					apf_io_pkg::OFS_MEMCARD:     memory_card_enable <= bridge_wr_data[1:0];
					apf_io_pkg::OFS_OVERCLOCK:   cpu_overclock <= bridge_wr_data[0];
					apf_io_pkg::OFS_VIDEO_MODE:  video_mode <= bridge_wr_data[0];
					apf_io_pkg::OFS_SCREEN_X:    screen_x_pos <= bridge_wr_data;
					apf_io_pkg::OFS_SCREEN_Y:    screen_y_pos <= bridge_wr_data;
					apf_io_pkg::OFS_VIDEO_RATIO: video_ratio <= bridge_wr_data[2:0];
					apf_io_pkg::OFS_CH_ENABLE:   ch_enable <= bridge_wr_data[5:0];
					apf_io_pkg::OFS_SND_ENABLE:  snd_enable <= bridge_wr_data[3:0];
					apf_io_pkg::OFS_PCHIP_MAIN:  pchip_main <= bridge_wr_data[0];
					apf_io_pkg::OFS_PCHIP_SUB:   pchip_sub <= bridge_wr_data[2:0];
					default: ;
				endcase
			end
		end
	end

	// main chip wins, sub modes 1..5 sit at 3..7
	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			cart_pchip <= 4'd0;
		end else if (pchip_main) begin
			cart_pchip <= 4'd2;
		end else begin
			case (pchip_sub)
				3'd1, 3'd2, 3'd3, 3'd4, 3'd5: cart_pchip <= {1'b0, pchip_sub} + 4'd2;
				default: cart_pchip <= 4'd0;
			endcase
		end
	end

	// core reset is a strobe and reads as zero
	always_comb begin
		case (ofs)
			apf_io_pkg::OFS_DIPSW:       cfg_rd_data = apf_io_pkg::data_t'(dipsw);
			apf_io_pkg::OFS_SYSTEM_TYPE: cfg_rd_data = apf_io_pkg::data_t'(system_type);
			apf_io_pkg::OFS_MEMCARD:     cfg_rd_data = apf_io_pkg::data_t'(memory_card_enable);
			apf_io_pkg::OFS_OVERCLOCK:   cfg_rd_data = apf_io_pkg::data_t'(cpu_overclock);
			apf_io_pkg::OFS_VIDEO_MODE:  cfg_rd_data = apf_io_pkg::data_t'(video_mode);
			apf_io_pkg::OFS_SCREEN_X:    cfg_rd_data = screen_x_pos;
			apf_io_pkg::OFS_SCREEN_Y:    cfg_rd_data = screen_y_pos;
			apf_io_pkg::OFS_VIDEO_RATIO: cfg_rd_data = apf_io_pkg::data_t'(video_ratio);
			apf_io_pkg::OFS_CH_ENABLE:   cfg_rd_data = apf_io_pkg::data_t'(ch_enable);
			apf_io_pkg::OFS_SND_ENABLE:  cfg_rd_data = apf_io_pkg::data_t'(snd_enable);
			apf_io_pkg::OFS_PCHIP_MAIN:  cfg_rd_data = apf_io_pkg::data_t'(pchip_main);
			apf_io_pkg::OFS_PCHIP_SUB:   cfg_rd_data = apf_io_pkg::data_t'(pchip_sub);
			default:                     cfg_rd_data = '0;
		endcase
	end

endmodule

//--- design/rom_region_mask.sv
// --------------------
// address mask for one rom region
// the highest set offset bit is smeared down to bit 0
// --------------------

`timescale 1ns/10ps

module rom_region_mask #(
	parameter int MASK_W = 19
) (
	input  logic              clk_74a,
	input  logic              reset_l_main,
	input  logic              hit,
	input  logic [MASK_W-1:0] offset,
	output logic [MASK_W-1:0] mask
);

	logic [MASK_W-1:0] smear;

	// running or from the top bit downward
	always_comb begin
		smear[MASK_W-1] = offset[MASK_W-1];
		for (int i = MASK_W - 2; i >= 0; i--) begin
			smear[i] = smear[i+1] | offset[i];
		end
	end

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			mask <= '0;
		end else if (hit) begin
			mask <= smear;
		end
	end

endmodule

//--- design/rom_mask_track.sv
// --------------------
// watches host bridge writes into the rom regions
// keeps one size mask per region, p2, m, s and v1
// --------------------

`timescale 1ns/10ps

module rom_mask_track (
	input  logic                             clk_74a,
	input  logic                             reset_l_main,
	input  logic                             bridge_wr,
	input  apf_io_pkg::addr_t                bridge_addr,
	output logic [apf_io_pkg::P2_MASK_W-1:0] p2_rom_mask,
	output logic [apf_io_pkg::M_MASK_W-1:0]  m_rom_mask,
	output logic [apf_io_pkg::S_MASK_W-1:0]  s_rom_mask,
	output logic [apf_io_pkg::V1_MASK_W-1:0] v1_rom_mask
);

	logic p2_hit;
	logic m_hit;
	logic s_hit;
	logic v1_hit;

	// prefix compares use the width of each region constant
	assign m_hit  = bridge_wr &&
		(bridge_addr[31 -: $bits(apf_io_pkg::M_REGION)] == apf_io_pkg::M_REGION);
	assign s_hit  = bridge_wr &&
		(bridge_addr[31 -: $bits(apf_io_pkg::S_REGION)] == apf_io_pkg::S_REGION);
	assign v1_hit = bridge_wr &&
		(bridge_addr[31 -: $bits(apf_io_pkg::V1_REGION)] == apf_io_pkg::V1_REGION);

	// p2 last, m and s never double as p2
	assign p2_hit = bridge_wr && !m_hit && !s_hit &&
		(bridge_addr[31 -: $bits(apf_io_pkg::P2_REGION)] == apf_io_pkg::P2_REGION);

	rom_region_mask #(.MASK_W(apf_io_pkg::P2_MASK_W)) i_p2_mask (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.hit          (p2_hit),
		.offset       (bridge_addr[apf_io_pkg::P2_MASK_W-1:0]),
		.mask         (p2_rom_mask)
	);

	rom_region_mask #(.MASK_W(apf_io_pkg::M_MASK_W)) i_m_mask (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.hit          (m_hit),
		.offset       (bridge_addr[apf_io_pkg::M_MASK_W-1:0]),
		.mask         (m_rom_mask)
	);

	rom_region_mask #(.MASK_W(apf_io_pkg::S_MASK_W)) i_s_mask (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.hit          (s_hit),
		.offset       (bridge_addr[apf_io_pkg::S_MASK_W-1:0]),
		.mask         (s_rom_mask)
	);

	rom_region_mask #(.MASK_W(apf_io_pkg::V1_MASK_W)) i_v1_mask (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.hit          (v1_hit),
		.offset       (bridge_addr[apf_io_pkg::V1_MASK_W-1:0]),
		.mask         (v1_rom_mask)
	);

endmodule

//--- design/core_status.sv
// --------------------
// registered read word for the host bridge
// restart hold counter that gates start_system
// --------------------

`timescale 1ns/10ps

module core_status (
	input  logic                             clk_74a,
	input  logic                             reset_l_main,
	input  logic                             bridge_rd,
	input  apf_io_pkg::addr_t                bridge_addr,
	input  apf_io_pkg::data_t                cfg_rd_data,
	input  logic [apf_io_pkg::P2_MASK_W-1:0] p2_rom_mask,
	input  logic [apf_io_pkg::M_MASK_W-1:0]  m_rom_mask,
	input  logic [apf_io_pkg::S_MASK_W-1:0]  s_rom_mask,
	input  logic [apf_io_pkg::V1_MASK_W-1:0] v1_rom_mask,
	input  logic                             restart_req,
	input  logic                             dataslot_allcomplete,
	input  logic                             core_run,
	output apf_io_pkg::data_t                bridge_rd_data,
	output logic                             start_system
);

	typedef logic [$clog2(apf_io_pkg::RESTART_HOLD + 1)-1:0] hold_cnt_t;

	apf_io_pkg::data_t mask_rd_data;
	apf_io_pkg::data_t rd_word;
	hold_cnt_t         hold_cnt;

	always_comb begin
		case (bridge_addr[15:0])
			apf_io_pkg::MOFS_P2: mask_rd_data = apf_io_pkg::data_t'(p2_rom_mask);
			apf_io_pkg::MOFS_M:  mask_rd_data = apf_io_pkg::data_t'(m_rom_mask);
			apf_io_pkg::MOFS_S:  mask_rd_data = apf_io_pkg::data_t'(s_rom_mask);
			apf_io_pkg::MOFS_V1: mask_rd_data = apf_io_pkg::data_t'(v1_rom_mask);
			default:             mask_rd_data = '0;
		endcase
	end

	// anything outside the two spaces reads zero
	always_comb begin
		case (bridge_addr[31:24])
			apf_io_pkg::CFG_SPACE:  rd_word = cfg_rd_data;
			apf_io_pkg::MASK_SPACE: rd_word = mask_rd_data;
			default:                rd_word = '0;
		endcase
	end

	// held until the next read strobe
	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			bridge_rd_data <= '0;
		end else if (bridge_rd) begin
			bridge_rd_data <= rd_word;
		end
	end

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			hold_cnt     <= '0;
			start_system <= 1'b0;
		end else begin
			if (restart_req) begin
				hold_cnt <= hold_cnt_t'(apf_io_pkg::RESTART_HOLD);
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
			// drops straight away on a request, counter still shows the old value
			start_system <= !restart_req && (hold_cnt == '0) &&
				dataslot_allcomplete && core_run;
		end
	end

endmodule

//--- design/apf_io.sv
// --------------------
// host bridge handoff top, configuration side only
// option registers, rom masks, read word and core start
// --------------------

`timescale 1ns/10ps

module apf_io (
	input  logic                             clk_74a,
	input  logic                             reset_l_main,
	input  logic                             bridge_wr,
	input  logic                             bridge_rd,
	input  apf_io_pkg::addr_t                bridge_addr,
	input  apf_io_pkg::data_t                bridge_wr_data,
	output apf_io_pkg::data_t                bridge_rd_data,
	input  logic                             dataslot_allcomplete,
	input  logic                             core_run,
	output logic                             start_system,
	output logic [7:0]                       dipsw,
	output logic                             system_type,
	output logic [1:0]                       memory_card_enable,
	output logic                             cpu_overclock,
	output logic                             video_mode,
	output logic [2:0]                       video_ratio,
	output apf_io_pkg::data_t                screen_x_pos,
	output apf_io_pkg::data_t                screen_y_pos,
	output logic [5:0]                       ch_enable,
	output logic [3:0]                       snd_enable,
	output logic [3:0]                       cart_pchip,
	output logic [apf_io_pkg::P2_MASK_W-1:0] p2_rom_mask,
	output logic [apf_io_pkg::M_MASK_W-1:0]  m_rom_mask,
	output logic [apf_io_pkg::S_MASK_W-1:0]  s_rom_mask,
	output logic [apf_io_pkg::V1_MASK_W-1:0] v1_rom_mask
);

	apf_io_pkg::data_t cfg_rd_data;
	logic              restart_req;

	apf_cfg_regs i_cfg_regs (
		.clk_74a            (clk_74a),
		.reset_l_main       (reset_l_main),
		.bridge_wr          (bridge_wr),
		.bridge_addr        (bridge_addr),
		.bridge_wr_data     (bridge_wr_data),
		.dipsw              (dipsw),
		.system_type        (system_type),
		.memory_card_enable (memory_card_enable),
		.cpu_overclock      (cpu_overclock),
		.video_mode         (video_mode),
		.video_ratio        (video_ratio),
		.screen_x_pos       (screen_x_pos),
		.screen_y_pos       (screen_y_pos),
		.ch_enable          (ch_enable),
		.snd_enable         (snd_enable),
		.cart_pchip         (cart_pchip),
		.restart_req        (restart_req),
		.cfg_rd_data        (cfg_rd_data)
	);

	// masks go out and back into the read path
	rom_mask_track i_mask_track (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.bridge_wr    (bridge_wr),
		.bridge_addr  (bridge_addr),
		.p2_rom_mask  (p2_rom_mask),
		.m_rom_mask   (m_rom_mask),
		.s_rom_mask   (s_rom_mask),
		.v1_rom_mask  (v1_rom_mask)
	);

	core_status i_core_status (
		.clk_74a              (clk_74a),
		.reset_l_main         (reset_l_main),
		.bridge_rd            (bridge_rd),
		.bridge_addr          (bridge_addr),
		.cfg_rd_data          (cfg_rd_data),
		.p2_rom_mask          (p2_rom_mask),
		.m_rom_mask           (m_rom_mask),
		.s_rom_mask           (s_rom_mask),
		.v1_rom_mask          (v1_rom_mask),
		.restart_req          (restart_req),
		.dataslot_allcomplete (dataslot_allcomplete),
		.core_run             (core_run),
		.bridge_rd_data       (bridge_rd_data),
		.start_system         (start_system)
	);

endmodule

//--- verif/tb_clk_gen.sv
// --------------------
// clock and reset source for the testbench
// 8 ns clk_74a, reset_l_main low for the first 10 cycles
// --------------------

`timescale 1ns/10ps

module tb_clk_gen (
	output logic clk_74a,
	output logic reset_l_main
);

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 10;

	initial begin
		clk_74a = 1'b0;
		forever #(CLK_PERIOD / 2) clk_74a = ~clk_74a;
	end

	initial begin
		reset_l_main = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_74a);
		#1;
		reset_l_main = 1'b1;
	end

endmodule

//--- verif/apf_io_chk.sv
// --------------------
// protocol and timing assertions for apf_io, attached with bind
// bridge strobes, restart drop and mask update timing
// --------------------

`timescale 1ns/10ps

module apf_io_chk (
	input logic                             clk_74a,
	input logic                             reset_l_main,
	input logic                             bridge_wr,
	input logic                             bridge_rd,
	input logic                             restart_req,
	input logic                             start_system,
	input logic [apf_io_pkg::P2_MASK_W-1:0] p2_rom_mask,
	input logic [apf_io_pkg::M_MASK_W-1:0]  m_rom_mask,
	input logic [apf_io_pkg::S_MASK_W-1:0]  s_rom_mask,
	input logic [apf_io_pkg::V1_MASK_W-1:0] v1_rom_mask
);

	int unsigned assert_errs = 0;

	a_no_rd_wr: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		!(bridge_rd && bridge_wr))
	else begin
		assert_errs++;
		$error("bridge read and write strobes high together");
	end

	a_start_drop: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		restart_req |=> !start_system)
	else begin
		assert_errs++;
		$error("start_system still high after restart request");
	end

	// masks only move on the edge after a write strobe
	a_mask_on_wr: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		!$stable({p2_rom_mask, m_rom_mask, s_rom_mask, v1_rom_mask}) |-> $past(bridge_wr))
	else begin
		assert_errs++;
		$error("rom mask changed without a bridge write");
	end

endmodule

//--- verif/apf_io_tb.sv
// --------------------
// testbench for the host bridge handoff block
// option writes and reads, rom masks, chip mode and restart hold
// --------------------

`timescale 1ns/10ps

module apf_io_tb;

	typedef logic [apf_io_pkg::V1_MASK_W-1:0] mask_t;

	localparam int HOLD         = apf_io_pkg::RESTART_HOLD;
	localparam int N_OPT_ROUNDS = 3;
	localparam int N_MASK_WR    = 6;
	localparam int N_OUTSIDE    = 8;
	localparam int STIM_CYCLES  = 13 * (2 + 3 * N_OPT_ROUNDS) + 12 * N_MASK_WR + 80 +
		2 * N_OUTSIDE + 5 * (HOLD + 8);
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 4 * HOLD;
	localparam logic [15:0] OPT_OFS [0:12] = '{
		apf_io_pkg::OFS_CORE_RESET, apf_io_pkg::OFS_DIPSW, apf_io_pkg::OFS_SYSTEM_TYPE,
		apf_io_pkg::OFS_MEMCARD, apf_io_pkg::OFS_OVERCLOCK, apf_io_pkg::OFS_VIDEO_MODE,
		apf_io_pkg::OFS_SCREEN_X, apf_io_pkg::OFS_SCREEN_Y, apf_io_pkg::OFS_VIDEO_RATIO,
		apf_io_pkg::OFS_CH_ENABLE, apf_io_pkg::OFS_SND_ENABLE, apf_io_pkg::OFS_PCHIP_MAIN,
		apf_io_pkg::OFS_PCHIP_SUB};

	logic clk_74a, reset_l_main, bridge_wr, bridge_rd, dataslot_allcomplete, core_run;
	logic start_system, system_type, cpu_overclock, video_mode;
	apf_io_pkg::addr_t bridge_addr;
	apf_io_pkg::data_t bridge_wr_data, bridge_rd_data, screen_x_pos, screen_y_pos;
	logic [7:0] dipsw;
	logic [1:0] memory_card_enable;
	logic [2:0] video_ratio;
	logic [5:0] ch_enable;
	logic [3:0] snd_enable, cart_pchip;
	logic [apf_io_pkg::P2_MASK_W-1:0] p2_rom_mask;
	logic [apf_io_pkg::M_MASK_W-1:0]  m_rom_mask;
	logic [apf_io_pkg::S_MASK_W-1:0]  s_rom_mask;
	logic [apf_io_pkg::V1_MASK_W-1:0] v1_rom_mask;

	logic [31:0] rng_state;
	apf_io_pkg::data_t exp_q[$];
	logic rd_pending;
	mask_t exp_mask [0:3];
	int data_errs, mask_errs, ctrl_errs, cycle_cnt;

	tb_clk_gen i_clk_gen (.clk_74a(clk_74a), .reset_l_main(reset_l_main));

	apf_io i_dut (.*);

	bind apf_io apf_io_chk i_chk (
		.clk_74a(clk_74a), .reset_l_main(reset_l_main), .bridge_wr(bridge_wr),
		.bridge_rd(bridge_rd), .restart_req(restart_req), .start_system(start_system),
		.p2_rom_mask(p2_rom_mask), .m_rom_mask(m_rom_mask), .s_rom_mask(s_rom_mask),
		.v1_rom_mask(v1_rom_mask));

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// expected read value is the write data cut to the register width
	function automatic apf_io_pkg::data_t opt_ref(input logic [15:0] ofs,
			input apf_io_pkg::data_t d);
		int w;
		case (ofs)
			apf_io_pkg::OFS_DIPSW: w = 8;
			apf_io_pkg::OFS_MEMCARD: w = 2;
			apf_io_pkg::OFS_VIDEO_RATIO, apf_io_pkg::OFS_PCHIP_SUB: w = 3;
			apf_io_pkg::OFS_CH_ENABLE: w = 6;
			apf_io_pkg::OFS_SND_ENABLE: w = 4;
			apf_io_pkg::OFS_SCREEN_X, apf_io_pkg::OFS_SCREEN_Y: w = 32;
			apf_io_pkg::OFS_SYSTEM_TYPE, apf_io_pkg::OFS_OVERCLOCK: w = 1;
			apf_io_pkg::OFS_VIDEO_MODE, apf_io_pkg::OFS_PCHIP_MAIN: w = 1;
			default: w = 0;
		endcase
		if (w == 32) return d;
		return d & ((32'd1 << w) - 1);
	endfunction

	function automatic apf_io_pkg::data_t reset_ref(input logic [15:0] ofs);
		case (ofs)
			apf_io_pkg::OFS_DIPSW: return 32'hFF;
			apf_io_pkg::OFS_SYSTEM_TYPE: return 32'h1;
			apf_io_pkg::OFS_CH_ENABLE: return 32'h3F;
			apf_io_pkg::OFS_SND_ENABLE: return 32'hF;
			default: return 32'h0;
		endcase
	endfunction

	// all ones up to and including the highest set offset bit
	function automatic mask_t smear_ref(input mask_t off, input int w);
		mask_t m;
		m = '0;
		for (int i = 0; i < w; i++) begin
			if (off[i]) m = (mask_t'(1) << (i + 1)) - 1;
		end
		return m;
	endfunction

	function automatic logic [3:0] pchip_ref(input logic main, input logic [2:0] sub);
		if (main) return 4'd2;
		case (sub)
			3'd1: return 4'd3;
			3'd2: return 4'd4;
			3'd3: return 4'd5;
			3'd4: return 4'd6;
			3'd5: return 4'd7;
			default: return 4'd0;
		endcase
	endfunction

	// region 0 p2, 1 m, 2 s, 3 v1
	function automatic apf_io_pkg::addr_t region_base(input int r);
		case (r)
			0: return 32'h1000_0000;
			1: return 32'h10F8_0000;
			2: return 32'h10C0_0000;
			default: return 32'h2000_0000;
		endcase
	endfunction

	function automatic int region_width(input int r);
		return (r == 0) ? 23 : (r == 3) ? 24 : 19;
	endfunction

	function automatic mask_t mask_out(input int r);
		case (r)
			0: return mask_t'(p2_rom_mask);
			1: return mask_t'(m_rom_mask);
			2: return mask_t'(s_rom_mask);
			default: return v1_rom_mask;
		endcase
	endfunction

	function automatic apf_io_pkg::addr_t cfg_addr(input logic [15:0] ofs);
		return {8'hF0, 8'h00, ofs};
	endfunction

	task automatic check_data(input apf_io_pkg::data_t got, input apf_io_pkg::data_t exp,
			input string what);
		if (got !== exp) begin
			data_errs++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_mask(input mask_t got, input mask_t exp, input string what);
		if (got !== exp) begin
			mask_errs++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			ctrl_errs++;
			$display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_option_out(input logic [15:0] ofs, input apf_io_pkg::data_t exp);
		case (ofs)
			apf_io_pkg::OFS_DIPSW: check_data(32'(dipsw), exp, "dipsw");
			apf_io_pkg::OFS_SYSTEM_TYPE: check_data(32'(system_type), exp, "system_type");
			apf_io_pkg::OFS_MEMCARD: check_data(32'(memory_card_enable), exp, "memory_card_enable");
			apf_io_pkg::OFS_OVERCLOCK: check_data(32'(cpu_overclock), exp, "cpu_overclock");
			apf_io_pkg::OFS_VIDEO_MODE: check_data(32'(video_mode), exp, "video_mode");
			apf_io_pkg::OFS_SCREEN_X: check_data(screen_x_pos, exp, "screen_x_pos");
			apf_io_pkg::OFS_SCREEN_Y: check_data(screen_y_pos, exp, "screen_y_pos");
			apf_io_pkg::OFS_VIDEO_RATIO: check_data(32'(video_ratio), exp, "video_ratio");
			apf_io_pkg::OFS_CH_ENABLE: check_data(32'(ch_enable), exp, "ch_enable");
			apf_io_pkg::OFS_SND_ENABLE: check_data(32'(snd_enable), exp, "snd_enable");
			default: ;
		endcase
	endtask

	task automatic next_cycle();
		@(posedge clk_74a);
		#1;
	endtask

	task automatic bus_write(input apf_io_pkg::addr_t addr, input apf_io_pkg::data_t data);
		bridge_wr      = 1'b1;
		bridge_addr    = addr;
		bridge_wr_data = data;
		next_cycle();
		bridge_wr = 1'b0;
	endtask

	// expected word is queued for the compare process one cycle later
	task automatic bus_read(input apf_io_pkg::addr_t addr, input apf_io_pkg::data_t exp);
		exp_q.push_back(exp);
		bridge_rd   = 1'b1;
		bridge_addr = addr;
		next_cycle();
		bridge_rd = 1'b0;
	endtask

	task automatic wait_start_high();
		int n;
		n = 0;
		while (start_system !== 1'b1 && n < HOLD + 8) begin
			next_cycle();
			n++;
		end
		check_bit(start_system, 1'b1, "start_system before restart");
	endtask

	task automatic check_restart(input logic [15:0] ofs, input apf_io_pkg::data_t data);
		int n;
		wait_start_high();
		bus_write(cfg_addr(ofs), data);
		next_cycle();
		check_bit(start_system, 1'b0, "start_system after restart write");
		n = 0;
		while (start_system !== 1'b1 && n < HOLD + 8) begin
			next_cycle();
			n++;
		end
		check_bit(start_system, 1'b1, "start_system after restart hold");
		if (n < HOLD || n > HOLD + 4) begin
			ctrl_errs++;
			$display("[ERROR] %0t: restart hold lasted %0d cycles, expected %0d to %0d",
				$time, n, HOLD, HOLD + 4);
		end
	endtask

	always @(posedge clk_74a) begin
		if (rd_pending && exp_q.size() > 0) begin
			check_data(bridge_rd_data, exp_q.pop_front(), "bridge read data");
		end
		rd_pending = bridge_rd;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk_74a);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, the tests did not complete", TIMEOUT_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		apf_io_pkg::data_t d;
		apf_io_pkg::addr_t a;
		mask_t off;
		logic seen_high;
		int total;
		bridge_wr = 1'b0;
		bridge_rd = 1'b0;
		bridge_addr = '0;
		bridge_wr_data = '0;
		dataslot_allcomplete = 1'b0;
		core_run = 1'b0;
		rng_state = 32'h886f;
		rd_pending = 1'b0;
		data_errs = 0;
		mask_errs = 0;
		ctrl_errs = 0;
		wait (reset_l_main === 1'b1);
		next_cycle();

		// reset state
		check_bit(start_system, 1'b0, "start_system after reset");
		for (int i = 0; i < 13; i++) begin
			bus_read(cfg_addr(OPT_OFS[i]), reset_ref(OPT_OFS[i]));
		end
		for (int r = 0; r < 4; r++) begin
			exp_mask[r] = '0;
			check_mask(mask_out(r), '0, "mask after reset");
			bus_read({8'hF1, 8'h00, 16'(4 * r)}, '0);
		end

		// option writes with random data
		for (int n = 0; n < N_OPT_ROUNDS; n++) begin
			for (int i = 0; i < 13; i++) begin
				d = next_rand();
				bus_write(cfg_addr(OPT_OFS[i]), d);
				check_option_out(OPT_OFS[i], opt_ref(OPT_OFS[i], d));
				bus_read(cfg_addr(OPT_OFS[i]), opt_ref(OPT_OFS[i], d));
			end
		end

		// rom region writes at random offsets of varied size
		for (int r = 0; r < 4; r++) begin
			for (int n = 0; n < N_MASK_WR; n++) begin
				a = next_rand();
				off = mask_t'((next_rand() >> a[4:0]) & ((32'd1 << region_width(r)) - 1));
				bus_write(region_base(r) | 32'(off), next_rand());
				exp_mask[r] = smear_ref(off, region_width(r));
				check_mask(mask_out(r), exp_mask[r], "mask output");
				bus_read({8'hF1, 8'h00, 16'(4 * r)}, 32'(exp_mask[r]));
			end
		end
		for (int r = 0; r < 4; r++) begin
			check_mask(mask_out(r), exp_mask[r], "mask after all regions");
		end

		// chip mode pairs with random upper data bits
		for (int m = 0; m < 2; m++) begin
			for (int s = 0; s < 8; s++) begin
				bus_write(cfg_addr(apf_io_pkg::OFS_PCHIP_MAIN), 32'(m) | (next_rand() & ~32'h1));
				bus_write(cfg_addr(apf_io_pkg::OFS_PCHIP_SUB), 32'(s) | (next_rand() & ~32'h7));
				next_cycle();
				check_data(32'(cart_pchip), 32'(pchip_ref(m[0], s[2:0])), "cart_pchip");
			end
		end

		// restart triggers
		dataslot_allcomplete = 1'b1;
		core_run = 1'b1;
		check_restart(apf_io_pkg::OFS_CORE_RESET, next_rand() | 32'h1);
		check_restart(apf_io_pkg::OFS_SYSTEM_TYPE, next_rand());
		check_restart(apf_io_pkg::OFS_OVERCLOCK, next_rand());
		dataslot_allcomplete = 1'b0;
		bus_write(cfg_addr(apf_io_pkg::OFS_SYSTEM_TYPE), next_rand());
		seen_high = 1'b0;
		repeat (HOLD + 8) begin
			next_cycle();
			seen_high = seen_high | start_system;
		end
		check_bit(seen_high, 1'b0, "start_system rose without dataslot_allcomplete");
		dataslot_allcomplete = 1'b1;
		repeat (2) next_cycle();
		check_bit(start_system, 1'b1, "start_system after dataslot_allcomplete");

		// reads outside both spaces and of unknown offsets
		for (int n = 0; n < N_OUTSIDE; n++) begin
			a = next_rand();
			if (a[31:25] == 7'b1111_000) a[25] = 1'b1;
			bus_read(a, '0);
		end
		bus_read(cfg_addr(16'h0000), '0);
		bus_read(cfg_addr(16'h0114), '0);
		bus_read(cfg_addr(16'h0400), '0);
		bus_read(cfg_addr(16'hFFFC), '0);
		bus_read({8'hF1, 8'h00, 16'h0010}, '0);
		bus_read({8'hF1, 8'h00, 16'h0100}, '0);

		repeat (2) next_cycle();
		if (exp_q.size() != 0) begin
			data_errs++;
			$display("%0d read results were never compared", exp_q.size());
		end
		total = data_errs + mask_errs + ctrl_errs + int'(i_dut.i_chk.assert_errs);
		$display("errors: data %0d, mask %0d, control %0d, assertion %0d", data_errs,
			mask_errs, ctrl_errs, i_dut.i_chk.assert_errs);
		if (total == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- compile.f
design/apf_io_pkg.sv
design/apf_cfg_regs.sv
design/rom_region_mask.sv
design/rom_mask_track.sv
design/core_status.sv
design/apf_io.sv
verif/tb_clk_gen.sv
verif/apf_io_chk.sv
verif/apf_io_tb.sv
